// File: bench/lwc_tests.txt
# T name | P pdi word (hex) | S sdi word (hex) | E expected do word (hex) and do_last
# Key word 0F1E2D3C is loaded first, A5A5A5A5 in the last test
T key_load_encrypt_8
P 70000000
S C2000004
S 0F1E2D3C
P 20000000
P 42000008
P 11223344
P 55667788
E 52000008 0
E 1E3C1E78 0
E 5A785AB4 0
E E0000000 1
T decrypt_6
P 30000000
P 52000006
P A1B2C3D4
P E5F6AABB
E 42000006 0
E AEACEEE8 0
E EAE80000 0
E E0000000 1
T two_segments
P 20000000
P 40000004
P 01020304
P 42000003
P 0A0B0C0D
E 50000004 0
E 0E1C2E38 0
E 52000003 0
E 05152100 0
E E0000000 1
T empty_last_segment
P 20000000
P 42000000
E 52000000 0
E E0000000 1
T second_key_load
P 70000000
S C2000004
S A5A5A5A5
P 20000000
P 42000004
P 12345678
E 52000004 0
E B791F3DD 0
E E0000000 1

// File: bench/tb_lwc_wrapper.sv
////////////////////////////////////////////////////////////
// Testbench for lwc_wrapper, driven by bench/lwc_tests.txt
// Must be run from the project root for the data file path
////////////////////////////////////////////////////////////
module tb_lwc_wrapper;
    timeunit 1ns;
    timeprecision 100ps;

    import lwc_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;

    logic  clk;
    logic  rst_n;
    word_t pdi_data;
    logic  pdi_valid;
    logic  pdi_ready;
    word_t sdi_data;
    logic  sdi_valid;
    logic  sdi_ready;
    word_t do_data;
    logic  do_last;
    logic  do_valid;
    logic  do_ready;

    word_t pdi_q[$];
    word_t sdi_q[$];
    word_t exp_data_q[$];
    logic  exp_last_q[$];

    int error_count;
    int test_errors;
    int tests_run;
    int tests_failed;
    bit aborted;

    lwc_wrapper UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .pdi_ready (pdi_ready),
        .sdi_data  (sdi_data),
        .sdi_valid (sdi_valid),
        .sdi_ready (sdi_ready),
        .do_data   (do_data),
        .do_last   (do_last),
        .do_valid  (do_valid),
        .do_ready  (do_ready)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error %s: got %h, expected %h", name, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // Handshakes are sampled mid-cycle, inputs change on the falling edge
    task automatic run_test(input string name);
        int  pdi_idx;
        int  sdi_idx;
        int  cycles;
        bit  pending;
        pdi_idx     = 0;
        sdi_idx     = 0;
        cycles      = 0;
        test_errors = 0;
        pending     = 1'b1;
        while (pending && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            pdi_valid = (pdi_idx < pdi_q.size());
            pdi_data  = pdi_valid ? pdi_q[pdi_idx] : '0;
            sdi_valid = (sdi_idx < sdi_q.size());
            sdi_data  = sdi_valid ? sdi_q[sdi_idx] : '0;
            do_ready  = ($urandom % 4) != 0;
            #1;
            if (pdi_valid && pdi_ready) begin
                pdi_idx++;
            end
            if (sdi_valid && sdi_ready) begin
                sdi_idx++;
            end
            if (do_valid && do_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("%s: DO delivered a word that was not expected", name);
                    error_count++;
                    test_errors++;
                end else begin
                    check_value("do_data", do_data, exp_data_q.pop_front());
                    check_value("do_last", 32'(do_last), 32'(exp_last_q.pop_front()));
                end
            end
            cycles++;
            pending = (pdi_idx < pdi_q.size()) || (sdi_idx < sdi_q.size())
                      || (exp_data_q.size() > 0);
        end
        if (pending) begin
            $display("%s: timed out after %0d cycles, %0d DO words never arrived",
                     name, cycles, exp_data_q.size());
            error_count++;
            test_errors++;
            aborted = 1'b1;
        end else begin
            // Nothing may follow the status word
            @(negedge clk);
            pdi_valid = 1'b0;
            sdi_valid = 1'b0;
            do_ready  = 1'b1;
            #1;
            check_value("do_valid", 32'(do_valid), 32'h0);
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
        pdi_q.delete();
        sdi_q.delete();
        exp_data_q.delete();
        exp_last_q.delete();
    endtask

    initial begin
        int    fd;
        int    n;
        int    last_flag;
        string line;
        string tag;
        string name;
        word_t value;
        bit    have_test;
        void'($urandom(32'h9a74c093));
        clk          = 1'b0;
        rst_n        = 1'b0;
        pdi_data     = '0;
        pdi_valid    = 1'b0;
        sdi_data     = '0;
        sdi_valid    = 1'b0;
        do_ready     = 1'b0;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        have_test    = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("bench/lwc_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/lwc_tests.txt");
            error_count++;
        end else begin
            while (!aborted && $fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s", tag);
                if (n == 1 && tag == "T") begin
                    if (have_test) begin
                        run_test(name);
                    end
                    n = $sscanf(line, "%s %s", tag, name);
                    have_test = 1'b1;
                end else if (n == 1 && tag == "P") begin
                    n = $sscanf(line, "%s %h", tag, value);
                    pdi_q.push_back(value);
                end else if (n == 1 && tag == "S") begin
                    n = $sscanf(line, "%s %h", tag, value);
                    sdi_q.push_back(value);
                end else if (n == 1 && tag == "E") begin
                    n = $sscanf(line, "%s %h %d", tag, value, last_flag);
                    exp_data_q.push_back(value);
                    exp_last_q.push_back(last_flag != 0);
                end
            end
            if (have_test && !aborted) begin
                run_test(name);
            end
            $fclose(fd);
        end
        if (tests_run == 0) begin
            $display("no tests were found in the data file");
            error_count++;
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the LWC wrapper testbench with Verilator and runs it from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_lwc_wrapper -f src.f -o sim_lwc
./obj_dir/sim_lwc | tee sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0

// File: source/lwc_controller.sv
////////////////////////////////////////////////////////////
// Instruction and segment sequencer for PDI and SDI
// Ready is only raised towards a port that offers a word
////////////////////////////////////////////////////////////
module lwc_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  lwc_pkg::word_t      pdi_data,
    input  logic                pdi_valid,
    output logic                pdi_ready,
    input  lwc_pkg::word_t      sdi_data,
    input  logic                sdi_valid,
    output logic                sdi_ready,
    input  logic                framer_ready,
    input  lwc_pkg::byte_cnt_t  word_bytes,
    input  logic                word_last,
    input  logic                seg_empty,
    output logic                seg_load,
    output logic                seg_step,
    output logic                key_load,
    output lwc_pkg::core_word_t core_in,
    output logic                hdr_write,
    output logic                data_write,
    output logic                status_write,
    output logic                decrypt
);
    import lwc_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    opcode_t     opcode;
    logic        decrypt_q;
    logic        last_seg_q;

    assign opcode = opcode_t'(pdi_data[WORD_W-1 -: 4]);

    always_comb begin
        state_next   = state;
        pdi_ready    = 1'b0;
        sdi_ready    = 1'b0;
        seg_load     = 1'b0;
        seg_step     = 1'b0;
        key_load     = 1'b0;
        hdr_write    = 1'b0;
        data_write   = 1'b0;
        status_write = 1'b0;
        case (state)
            S_INST: begin
                pdi_ready = pdi_valid;
                if (pdi_ready) begin
                    state_next = (opcode == OP_ACTKEY) ? S_KEY_HDR : S_SEG_HDR;
                end
            end
            S_KEY_HDR: begin
                sdi_ready = sdi_valid;
                if (sdi_ready) begin
                    state_next = S_KEY_DATA;
                end
            end
            S_KEY_DATA: begin
                sdi_ready = sdi_valid;
                key_load  = sdi_ready;
                if (sdi_ready) begin
                    state_next = S_INST;
                end
            end
            S_SEG_HDR: begin
                pdi_ready = pdi_valid & framer_ready;
                seg_load  = pdi_ready;
                hdr_write = pdi_ready;
                if (pdi_ready) begin
                    state_next = S_SEG_DATA;
                end
            end
            S_SEG_DATA: begin
                // Empty segment skips straight on
                if (seg_empty) begin
                    state_next = last_seg_q ? S_STATUS : S_SEG_HDR;
                end else begin
                    pdi_ready  = pdi_valid & framer_ready;
                    seg_step   = pdi_ready;
                    data_write = pdi_ready;
                    if (pdi_ready && word_last) begin
                        state_next = last_seg_q ? S_STATUS : S_SEG_HDR;
                    end
                end
            end
            S_STATUS: begin
                status_write = framer_ready;
                if (framer_ready) begin
                    state_next = S_INST;
                end
            end
            default: begin
                state_next = S_INST;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_INST;
            decrypt_q  <= 1'b0;
            last_seg_q <= 1'b0;
        end else begin
            state <= state_next;
            if (state == S_INST && pdi_ready && opcode != OP_ACTKEY) begin
                decrypt_q <= (opcode == OP_DEC);
            end
            if (seg_load) begin
                last_seg_q <= pdi_data[LAST_SEG_BIT];
            end
        end
    end

    assign core_in = '{data: pdi_data, bytes: word_bytes, last: word_last};
    assign decrypt = decrypt_q;

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {S_INST, S_KEY_HDR, S_KEY_DATA, S_SEG_HDR, S_SEG_DATA, S_STATUS});

    // Key segment header on SDI carries the key type
    a_key_hdr_type: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_KEY_HDR && sdi_ready) |-> sdi_data[WORD_W-1 -: 4] == SEG_KEY);

endmodule

// File: source/lwc_pkg.sv
////////////////////////////////////////////////////////////
// Widths, codes and types shared by the LWC wrapper
// PDI, SDI and DO are fixed at 32 bits, sizes in bytes
////////////////////////////////////////////////////////////
package lwc_pkg;

    localparam int WORD_W         = 32;
    localparam int SEG_SIZE_W     = 16;
    localparam int BYTES_PER_WORD = 4;
    localparam int LAST_SEG_BIT   = 25;
    localparam int OUT_FIFO_DEPTH = 2;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [SEG_SIZE_W-1:0] seg_size_t;
    // 0 to 4 valid bytes
    typedef logic [2:0]            byte_cnt_t;

    localparam word_t STATUS_SUCCESS = 32'hE000_0000;

    // Instruction in bits 31:28 of a PDI instruction word
    typedef enum logic [3:0] {
        OP_ENC    = 4'd2,
        OP_DEC    = 4'd3,
        OP_ACTKEY = 4'd7
    } opcode_t;

    // Type in bits 31:28 of a segment header
    typedef enum logic [3:0] {
        SEG_PT  = 4'd4,
        SEG_CT  = 4'd5,
        SEG_KEY = 4'd12
    } seg_type_t;

    typedef struct packed {
        word_t     data;
        byte_cnt_t bytes;
        logic      last;
    } core_word_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } do_word_t;

    typedef enum logic [2:0] {
        S_INST,
        S_KEY_HDR,
        S_KEY_DATA,
        S_SEG_HDR,
        S_SEG_DATA,
        S_STATUS
    } ctrl_state_t;

endpackage

// File: source/lwc_wrapper.sv
////////////////////////////////////////////////////////////
// LWC interface wrapper around a one-word XOR cipher core
// Key segment must be a single 4-byte word on SDI
// Malformed headers and unknown opcodes are not handled
////////////////////////////////////////////////////////////
module lwc_wrapper (
    input  logic           clk,
    input  logic           rst_n,
    input  lwc_pkg::word_t pdi_data,
    input  logic           pdi_valid,
    output logic           pdi_ready,
    input  lwc_pkg::word_t sdi_data,
    input  logic           sdi_valid,
    output logic           sdi_ready,
    output lwc_pkg::word_t do_data,
    output logic           do_last,
    output logic           do_valid,
    input  logic           do_ready
);
    import lwc_pkg::*;

    logic       framer_ready;
    logic       seg_load;
    logic       seg_step;
    logic       key_load;
    logic       hdr_write;
    logic       data_write;
    logic       status_write;
    logic       decrypt;
    byte_cnt_t  word_bytes;
    logic       word_last;
    logic       seg_empty;
    core_word_t core_in;
    do_word_t   core_out;
    do_word_t   framer_out;
    logic       fifo_write;
    logic       fifo_ready;
    do_word_t   fifo_out;

    lwc_controller u_controller (
        .clk          (clk),
        .rst_n        (rst_n),
        .pdi_data     (pdi_data),
        .pdi_valid    (pdi_valid),
        .pdi_ready    (pdi_ready),
        .sdi_data     (sdi_data),
        .sdi_valid    (sdi_valid),
        .sdi_ready    (sdi_ready),
        .framer_ready (framer_ready),
        .word_bytes   (word_bytes),
        .word_last    (word_last),
        .seg_empty    (seg_empty),
        .seg_load     (seg_load),
        .seg_step     (seg_step),
        .key_load     (key_load),
        .core_in      (core_in),
        .hdr_write    (hdr_write),
        .data_write   (data_write),
        .status_write (status_write),
        .decrypt      (decrypt)
    );

    segment_counter u_seg_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .seg_load   (seg_load),
        .seg_step   (seg_step),
        .size_in    (pdi_data[SEG_SIZE_W-1:0]),
        .word_bytes (word_bytes),
        .word_last  (word_last),
        .seg_empty  (seg_empty)
    );

    xor_core u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_load (key_load),
        .key_in   (sdi_data),
        .core_in  (core_in),
        .core_out (core_out)
    );

    output_framer u_framer (
        .hdr_write    (hdr_write),
        .data_write   (data_write),
        .status_write (status_write),
        .decrypt      (decrypt),
        .hdr_in       (pdi_data),
        .core_out     (core_out),
        .fifo_ready   (fifo_ready),
        .framer_ready (framer_ready),
        .fifo_write   (fifo_write),
        .framer_out   (framer_out)
    );

    output_fifo u_do_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (fifo_write),
        .wr_data  (framer_out),
        .wr_ready (fifo_ready),
        .rd_data  (fifo_out),
        .rd_valid (do_valid),
        .rd_ready (do_ready)
    );

    assign do_data = fifo_out.data;
    assign do_last = fifo_out.last;

endmodule

// File: source/output_fifo.sv
////////////////////////////////////////////////////////////
// Small circular FIFO on the DO stream
// Depth must be a power of two for pointer wrap
////////////////////////////////////////////////////////////
module output_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_valid,
    input  lwc_pkg::do_word_t wr_data,
    output logic              wr_ready,
    output lwc_pkg::do_word_t rd_data,
    output logic              rd_valid,
    input  logic              rd_ready
);
    import lwc_pkg::*;

    do_word_t                            mem [OUT_FIFO_DEPTH];
    logic [$clog2(OUT_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(OUT_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(OUT_FIFO_DEPTH):0]     count;
    logic                                do_wr;
    logic                                do_rd;

    assign wr_ready = (count != OUT_FIFO_DEPTH);
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign do_wr    = wr_valid & wr_ready;
    assign do_rd    = rd_valid & rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + do_wr;
            rd_ptr <= rd_ptr + do_rd;
            count  <= count + do_wr - do_rd;
        end
    end

    // Writer holds off by itself while the FIFO is full
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid |-> wr_ready);

    a_rd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)));

endmodule

// File: source/output_framer.sv
////////////////////////////////////////////////////////////
// DO word builder for headers, data and the status word
// At most one write strobe is high in any cycle
////////////////////////////////////////////////////////////
module output_framer (
    input  logic              hdr_write,
    input  logic              data_write,
    input  logic              status_write,
    input  logic              decrypt,
    input  lwc_pkg::word_t    hdr_in,
    input  lwc_pkg::do_word_t core_out,
    input  logic              fifo_ready,
    output logic              framer_ready,
    output logic              fifo_write,
    output lwc_pkg::do_word_t framer_out
);
    import lwc_pkg::*;

    seg_type_t out_type;
    word_t     out_hdr;

    assign out_type = decrypt ? SEG_PT : SEG_CT;

    // Type, last-segment bit and size, rest zero
    always_comb begin
        out_hdr                   = '0;
        out_hdr[WORD_W-1 -: 4]    = out_type;
        out_hdr[LAST_SEG_BIT]     = hdr_in[LAST_SEG_BIT];
        out_hdr[SEG_SIZE_W-1:0]   = hdr_in[SEG_SIZE_W-1:0];
    end

    always_comb begin
        if (status_write) begin
            framer_out = '{data: STATUS_SUCCESS, last: 1'b1};
        end else if (hdr_write) begin
            framer_out = '{data: out_hdr, last: 1'b0};
        end else begin
            framer_out = '{data: core_out.data, last: 1'b0};
        end
    end

    assign fifo_write   = hdr_write | data_write | status_write;
    assign framer_ready = fifo_ready;

endmodule

// File: source/segment_counter.sv
////////////////////////////////////////////////////////////
// Remaining-byte count of the current segment
// Load has priority over step in the same cycle
////////////////////////////////////////////////////////////
module segment_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               seg_load,
    input  logic               seg_step,
    input  lwc_pkg::seg_size_t size_in,
    output lwc_pkg::byte_cnt_t word_bytes,
    output logic               word_last,
    output logic               seg_empty
);
    import lwc_pkg::*;

    seg_size_t remaining;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (seg_load) begin
            remaining <= size_in;
        end else if (seg_step) begin
            // Final word may be partial
            if (word_last) begin
                remaining <= '0;
            end else begin
                remaining <= remaining - seg_size_t'(BYTES_PER_WORD);
            end
        end
    end

    assign word_last  = (remaining <= seg_size_t'(BYTES_PER_WORD));
    assign word_bytes = word_last ? byte_cnt_t'(remaining) : byte_cnt_t'(BYTES_PER_WORD);
    assign seg_empty  = (remaining == '0);

endmodule

// File: source/xor_core.sv
////////////////////////////////////////////////////////////
// One-word key XOR cipher, same operation both directions
// Bytes past the word's count read as zero, MSB first
////////////////////////////////////////////////////////////
module xor_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                key_load,
    input  lwc_pkg::word_t      key_in,
    input  lwc_pkg::core_word_t core_in,
    output lwc_pkg::do_word_t   core_out
);
    import lwc_pkg::*;

    word_t key;
    word_t byte_mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key <= '0;
        end else if (key_load) begin
            key <= key_in;
        end
    end

    // Byte 0 is the most significant one
    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            byte_mask[WORD_W-1-8*i -: 8] = (i < int'(core_in.bytes)) ? 8'hFF : 8'h00;
        end
    end

    assign core_out.data = (core_in.data ^ key) & byte_mask;
    assign core_out.last = core_in.last;

endmodule

// File: src.f
source/lwc_pkg.sv
source/segment_counter.sv
source/xor_core.sv
source/output_framer.sv
source/output_fifo.sv
source/lwc_controller.sv
source/lwc_wrapper.sv
bench/tb_lwc_wrapper.sv
